// File: include/win_settings.svh
`ifndef WIN_SETTINGS_SVH
`define WIN_SETTINGS_SVH

// frame limits, line buffer depth and row counter range
`define WIN_MAX_COLS            32
`define WIN_MAX_ROWS            32

// wishbone register map
`define WIN_ADR_MODE            2'd0
`define WIN_ADR_CONST           2'd1

// border mode codes
`define WIN_BORDER_CONSTANT     2'd0
`define WIN_BORDER_REPLICATE    2'd1
`define WIN_BORDER_REFLECT_101  2'd2

`endif

// File: source/win_stream_pkg.sv
`include "win_settings.svh"

package win_stream_pkg;

    typedef logic [7:0]                        pix_t;
    // nine 8-bit pixels fit in 12 bits
    typedef logic [11:0]                       sum_t;
    typedef logic [$clog2(`WIN_MAX_COLS)-1:0]  col_t;

    // position of one pixel inside its frame
    typedef struct packed {
        logic row_first;
        logic row_last;
        logic col_first;
        logic col_last;
    } pos_flags_t;

    typedef struct packed {
        pix_t data;
        logic row_first;
        logic row_last;
        logic col_first;
        logic col_last;
    } pix_beat_t;

    typedef struct packed {
        sum_t data;
        logic row_first;
        logic row_last;
        logic col_first;
        logic col_last;
    } sum_beat_t;

    // index is row * 3 + col, top-left neighbor at 0
    typedef pix_t [8:0] window_t;

endpackage

// File: source/win_cfg_pkg.sv
`include "win_settings.svh"

package win_cfg_pkg;

    // code 3 is not named and behaves as replicate
    typedef enum logic [1:0] {
        BORDER_CONSTANT    = `WIN_BORDER_CONSTANT,
        BORDER_REPLICATE   = `WIN_BORDER_REPLICATE,
        BORDER_REFLECT_101 = `WIN_BORDER_REFLECT_101
    } border_mode_t;

    typedef struct packed {
        border_mode_t        mode;
        win_stream_pkg::pix_t const_value;
    } win_cfg_t;

    typedef logic [1:0] wb_adr_t;
    typedef logic [7:0] wb_dat_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat_r;
    } wb_rsp_t;

endpackage

// File: source/win_cfg_regs.sv
`include "win_settings.svh"

module win_cfg_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  win_cfg_pkg::wb_req_t   wb_req,
    output win_cfg_pkg::wb_rsp_t   wb_rsp,
    output win_cfg_pkg::win_cfg_t  cfg
);
    import win_cfg_pkg::*;
    import win_stream_pkg::*;

    logic          ack_q;
    wb_dat_t       dat_r_q;
    border_mode_t  mode_q;
    pix_t          const_q;
    logic          req_go;
    wb_dat_t       rd_data;

    // new request seen, ack goes out next cycle and never twice in a row
    assign req_go = wb_req.cyc && wb_req.stb && !ack_q;

    // read mux
    always_comb begin
        case (wb_req.adr)
            `WIN_ADR_MODE:  rd_data = {6'b0, mode_q};
            `WIN_ADR_CONST: rd_data = const_q;
            default:        rd_data = '0;
        endcase
    end

    // ---------------------------------------------------------------------------
    // handshake and register storage
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            mode_q  <= BORDER_REFLECT_101;
            const_q <= '0;
        end else begin
            ack_q <= req_go;
            if (req_go && wb_req.we) begin
                case (wb_req.adr)
                    `WIN_ADR_MODE:  mode_q  <= border_mode_t'(wb_req.dat_w[1:0]);
                    `WIN_ADR_CONST: const_q <= wb_req.dat_w;
                    default:        ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_go) begin
            dat_r_q <= rd_data;
        end
    end

    assign wb_rsp.ack       = ack_q;
    assign wb_rsp.dat_r     = dat_r_q;
    assign cfg.mode         = mode_q;
    assign cfg.const_value  = const_q;

endmodule

// File: source/win_window_buf.sv
`include "win_settings.svh"

module win_window_buf (
    input  logic                        clk,
    input  logic                        rst_n,
    input  win_cfg_pkg::win_cfg_t       cfg,
    input  win_stream_pkg::pix_beat_t   s_beat,
    input  logic                        s_valid,
    output logic                        s_ready,
    output win_stream_pkg::window_t     w_window,
    output win_stream_pkg::pos_flags_t  w_flags,
    output logic                        w_valid
);
    import win_stream_pkg::*;
    import win_cfg_pkg::*;

    typedef logic [$clog2(`WIN_MAX_ROWS)-1:0] row_t;
    // one column of the window, 0 = top, 1 = center row, 2 = bottom
    typedef pix_t [2:0] pix3_t;

    typedef enum logic [1:0] {RUN, ROW_TAIL, FRAME_FLUSH} state_t;

    state_t      state;
    logic        accept;
    col_t        in_col;
    col_t        col_cnt;
    col_t        fcol;
    col_t        last_col;
    col_t        rd_col;
    row_t        in_row;
    row_t        row_cnt;
    logic        pending_flush;
    logic        ctr_have;
    logic        ctr_row_first;
    logic        ctr_row_last;
    win_cfg_t    frame_cfg;
    logic        next_valid;
    pos_flags_t  next_flags;
    pix3_t       feed;
    pix3_t       row_fill [3];

    // row r-1 and row r, the incoming beat is row r+1
    pix_t        lb_old [`WIN_MAX_COLS];
    pix_t        lb_new [`WIN_MAX_COLS];
    // three column history, 0 = left, 2 = right
    pix3_t       hist [3];

    assign s_ready = (state == RUN);
    assign accept  = s_valid && s_ready;
    assign in_col  = s_beat.col_first ? '0 : col_cnt;
    assign in_row  = s_beat.row_first ? '0 : row_cnt;
    // flush walks the stored rows, otherwise follow the input
    assign rd_col  = (state == FRAME_FLUSH) ? fcol : in_col;

    assign feed[0] = lb_old[rd_col];
    assign feed[1] = lb_new[rd_col];
    assign feed[2] = s_beat.data;

    // ---------------------------------------------------------------------------
    // control, counters and frame config
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= RUN;
            col_cnt       <= '0;
            row_cnt       <= '0;
            fcol          <= '0;
            last_col      <= '0;
            pending_flush <= 1'b0;
            ctr_have      <= 1'b0;
            ctr_row_first <= 1'b0;
            ctr_row_last  <= 1'b0;
            frame_cfg     <= '{mode: BORDER_REFLECT_101, const_value: '0};
            w_valid       <= 1'b0;
        end else begin
            w_valid <= next_valid;
            case (state)
                RUN: begin
                    if (accept) begin
                        col_cnt       <= in_col + 1'b1;
                        ctr_have      <= (in_row != '0);
                        ctr_row_first <= (in_row == row_t'(1));
                        ctr_row_last  <= 1'b0;
                        if (s_beat.row_first && s_beat.col_first) begin
                            frame_cfg <= cfg;
                        end
                        if (s_beat.col_last) begin
                            last_col      <= in_col;
                            row_cnt       <= in_row + 1'b1;
                            pending_flush <= s_beat.row_last;
                            state         <= ROW_TAIL;
                        end
                    end
                end
                ROW_TAIL: begin
                    pending_flush <= 1'b0;
                    if (pending_flush) begin
                        // last stored row becomes the center row
                        fcol          <= '0;
                        ctr_have      <= 1'b1;
                        ctr_row_first <= (row_cnt == row_t'(1));
                        ctr_row_last  <= 1'b1;
                        state         <= FRAME_FLUSH;
                    end else begin
                        state <= RUN;
                    end
                end
                FRAME_FLUSH: begin
                    fcol <= fcol + 1'b1;
                    if (fcol == last_col) begin
                        state <= ROW_TAIL;
                    end
                end
                default: state <= RUN;
            endcase
        end
    end

    // position of the window that comes out next cycle
    always_comb begin
        next_valid = 1'b0;
        next_flags = '0;
        case (state)
            RUN: begin
                next_valid           = accept && (in_col != '0) && (in_row != '0);
                next_flags.row_first = (in_row == row_t'(1));
                next_flags.col_first = (in_col == col_t'(1));
            end
            ROW_TAIL: begin
                next_valid           = ctr_have;
                next_flags.row_first = ctr_row_first;
                next_flags.row_last  = ctr_row_last;
                next_flags.col_first = (last_col == '0);
                next_flags.col_last  = 1'b1;
            end
            FRAME_FLUSH: begin
                next_valid           = (fcol != '0);
                next_flags.row_first = ctr_row_first;
                next_flags.row_last  = 1'b1;
                next_flags.col_first = (fcol == col_t'(1));
            end
            default: ;
        endcase
    end

    // line buffers and column history
    always_ff @(posedge clk) begin
        if (accept) begin
            lb_old[in_col] <= lb_new[in_col];
            lb_new[in_col] <= s_beat.data;
        end
        if (accept || state != RUN) begin
            hist[0] <= hist[1];
            hist[1] <= hist[2];
            hist[2] <= feed;
        end
        w_flags <= next_flags;
    end

    // ---------------------------------------------------------------------------
    // border substitution, columns first and then rows
    // ---------------------------------------------------------------------------
    function automatic pix3_t fill_edge(input pix3_t v, input logic lo_out,
                                        input logic hi_out, input win_cfg_t c);
        pix3_t r;
        r = v;
        case (c.mode)
            BORDER_CONSTANT: begin
                if (lo_out) r[0] = c.const_value;
                if (hi_out) r[2] = c.const_value;
            end
            BORDER_REFLECT_101: begin
                // length 1 has nothing to mirror, keep the edge
                if (lo_out) r[0] = hi_out ? v[1] : v[2];
                if (hi_out) r[2] = lo_out ? v[1] : v[0];
            end
            default: begin
                if (lo_out) r[0] = v[1];
                if (hi_out) r[2] = v[1];
            end
        endcase
        return r;
    endfunction

    always_comb begin
        pix3_t col_fill;
        for (int i = 0; i < 3; i++) begin
            row_fill[i] = fill_edge({hist[2][i], hist[1][i], hist[0][i]},
                                    w_flags.col_first, w_flags.col_last, frame_cfg);
        end
        for (int j = 0; j < 3; j++) begin
            col_fill = fill_edge({row_fill[2][j], row_fill[1][j], row_fill[0][j]},
                                 w_flags.row_first, w_flags.row_last, frame_cfg);
            for (int i = 0; i < 3; i++) begin
                w_window[i*3+j] = col_fill[i];
            end
        end
    end

endmodule

// File: source/win_sum_result.sv
module win_sum_result (
    input  logic                        clk,
    input  logic                        rst_n,
    input  win_stream_pkg::window_t     w_window,
    input  win_stream_pkg::pos_flags_t  w_flags,
    input  logic                        w_valid,
    output win_stream_pkg::sum_beat_t   m_beat,
    output logic                        m_valid
);
    import win_stream_pkg::*;

    // three pixels need two extra bits
    typedef logic [$bits(pix_t)+1:0] row_sum_t;

    row_sum_t  row_sum [3];
    sum_t      total;

    // ---------------------------------------------------------------------------
    // adder tree, row sums then the total
    // ---------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            row_sum[i] = row_sum_t'(w_window[i*3])
                       + row_sum_t'(w_window[i*3+1])
                       + row_sum_t'(w_window[i*3+2]);
        end
        total = sum_t'(row_sum[0]) + sum_t'(row_sum[1]) + sum_t'(row_sum[2]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else begin
            m_valid <= w_valid;
        end
    end

    // sum tagged with the center pixel position
    always_ff @(posedge clk) begin
        if (w_valid) begin
            m_beat.data      <= total;
            m_beat.row_first <= w_flags.row_first;
            m_beat.row_last  <= w_flags.row_last;
            m_beat.col_first <= w_flags.col_first;
            m_beat.col_last  <= w_flags.col_last;
        end
    end

endmodule

// File: source/win_filter_top.sv
module win_filter_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  win_cfg_pkg::wb_req_t       wb_req,
    output win_cfg_pkg::wb_rsp_t       wb_rsp,
    input  win_stream_pkg::pix_beat_t  s_beat,
    input  logic                       s_valid,
    output logic                       s_ready,
    output win_stream_pkg::sum_beat_t  m_beat,
    output logic                       m_valid
);
    import win_stream_pkg::*;
    import win_cfg_pkg::*;

    win_cfg_t    cfg;
    window_t     w_window;
    pos_flags_t  w_flags;
    logic        w_valid;

    // configuration port
    win_cfg_regs u_cfg_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .cfg    (cfg)
    );

    // line buffers and 3x3 window
    win_window_buf u_window_buf (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .s_beat   (s_beat),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .w_window (w_window),
        .w_flags  (w_flags),
        .w_valid  (w_valid)
    );

    // neighborhood sum
    win_sum_result u_sum_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .w_window (w_window),
        .w_flags  (w_flags),
        .w_valid  (w_valid),
        .m_beat   (m_beat),
        .m_valid  (m_valid)
    );

endmodule

// File: sim/tb_win_filter.sv
`include "win_settings.svh"

module tb_win_filter;
    import win_stream_pkg::*;
    import win_cfg_pkg::*;

    // pixels over all frames size the run limit
    localparam int TOTAL_PIXELS = 48 + 20 + 20 + 4 + 4 + 1 + 30 + 30;
    localparam int CYCLE_LIMIT  = 4 * TOTAL_PIXELS + 2000;

    logic       clk;
    logic       rst_n;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    pix_beat_t  s_beat;
    logic       s_valid;
    logic       s_ready;
    sum_beat_t  m_beat;
    logic       m_valid;

    logic [31:0] rng_state;
    pix_t        img [];
    sum_beat_t   exp_q [$];
    sum_beat_t   exp_beat;
    sum_beat_t   first_beat;
    sum_t        corner_exp;
    logic        ack_prev = 1'b0;
    int          err_cnt = 0;
    int          out_cnt = 0;
    int          cycle_cnt = 0;
    int          test_err_base = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          out_base;

    win_filter_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // checkers sampled at the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && m_valid) begin
            out_cnt++;
            if (out_cnt == out_base + 1) begin
                first_beat = m_beat;
            end
            assert (exp_q.size() != 0) else begin
                $display("output beat arrived with no expected value left");
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp_beat = exp_q.pop_front();
                assert (m_beat == exp_beat) else begin
                    $display("mismatch m_beat: got %h expected %h", m_beat, exp_beat);
                    err_cnt++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(ack_prev && wb_rsp.ack)) else begin
                $display("wishbone ack stayed high for two cycles");
                err_cnt++;
            end
            assert (!wb_rsp.ack || (wb_req.cyc && wb_req.stb)) else begin
                $display("wishbone ack raised without a request");
                err_cnt++;
            end
        end
        ack_prev = wb_rsp.ack;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // source index for a neighbor or -1 for the constant value
    function automatic int border_index(input int i, input int n, input logic [1:0] mode);
        int idx;
        idx = i;
        if (i < 0 || i >= n) begin
            case (mode)
                `WIN_BORDER_CONSTANT:    idx = -1;
                `WIN_BORDER_REFLECT_101: idx = (n == 1) ? 0 : ((i < 0) ? -i : 2 * n - 2 - i);
                default:                 idx = (i < 0) ? 0 : n - 1;
            endcase
        end
        return idx;
    endfunction

    // ------------------------------------------------------------------------
    // reference model and stimulus
    // ------------------------------------------------------------------------
    task automatic make_frame(input int rows, input int cols);
        img = new[rows * cols];
        foreach (img[i]) begin
            img[i] = pix_t'(next_rand() >> 8);
        end
    endtask

    task automatic queue_expected(input int rows, input int cols, input logic [1:0] mode,
                                  input pix_t cval);
        sum_beat_t b;
        int total;
        int rr;
        int cc;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                total = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        rr = border_index(r + dr, rows, mode);
                        cc = border_index(c + dc, cols, mode);
                        if (rr < 0 || cc < 0) begin
                            total += int'(cval);
                        end else begin
                            total += int'(img[rr * cols + cc]);
                        end
                    end
                end
                b.data      = sum_t'(total);
                b.row_first = (r == 0);
                b.row_last  = (r == rows - 1);
                b.col_first = (c == 0);
                b.col_last  = (c == cols - 1);
                exp_q.push_back(b);
            end
        end
    endtask

    // entered and left a few time units after a rising edge
    task automatic send_frame(input int rows, input int cols, input bit gaps);
        pix_beat_t b;
        int idle;
        bit taken;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                if (gaps) begin
                    idle = int'(next_rand() % 32'd4);
                    s_valid = 1'b0;
                    repeat (idle) begin
                        @(posedge clk);
                        #5;
                    end
                end
                b.data      = img[r * cols + c];
                b.row_first = (r == 0);
                b.row_last  = (r == rows - 1);
                b.col_first = (c == 0);
                b.col_last  = (c == cols - 1);
                s_beat  = b;
                s_valid = 1'b1;
                do begin
                    @(negedge clk);
                    taken = s_ready;
                    @(posedge clk);
                    #5;
                end while (!taken);
            end
        end
        s_valid = 1'b0;
    endtask

    task automatic run_frame(input int rows, input int cols, input logic [1:0] mode,
                             input pix_t cval, input bit gaps);
        make_frame(rows, cols);
        queue_expected(rows, cols, mode, cval);
        send_frame(rows, cols, gaps);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        #5;
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [7:0] dat,
                             output logic [7:0] rdata);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = dat;
        do begin
            @(negedge clk);
        end while (!wb_rsp.ack);
        rdata = wb_rsp.dat_r;
        @(posedge clk);
        #5;
        wb_req = '0;
    endtask

    task automatic reg_write(input logic [1:0] adr, input logic [7:0] dat);
        logic [7:0] ignored;
        wb_access(1'b1, adr, dat, ignored);
    endtask

    task automatic read_check(input logic [1:0] adr, input logic [7:0] expected);
        logic [7:0] got;
        wb_access(1'b0, adr, 8'h00, got);
        assert (got == expected) else begin
            $display("mismatch wb_rsp.dat_r at adr %h: got %h expected %h", adr, got, expected);
            err_cnt++;
        end
    endtask

    task automatic count_check(input int expected);
        assert (out_cnt - out_base == expected) else begin
            $display("wrong number of outputs: got %0d, expected %0d",
                     out_cnt - out_base, expected);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == test_err_base) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        wb_req    = '0;
        s_beat    = '0;
        s_valid   = 1'b0;
        rng_state = 32'h6159_c658;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;

        assert (s_ready && !m_valid && !wb_rsp.ack) else begin
            $display("mismatch s_ready m_valid wb_rsp.ack after reset: got %h %h %h",
                     s_ready, m_valid, wb_rsp.ack);
            $display("expected 1 0 0");
            err_cnt++;
        end
        read_check(`WIN_ADR_MODE, {6'b0, `WIN_BORDER_REFLECT_101});
        read_check(`WIN_ADR_CONST, 8'h00);
        reg_write(`WIN_ADR_MODE, {6'b0, `WIN_BORDER_REPLICATE});
        read_check(`WIN_ADR_MODE, {6'b0, `WIN_BORDER_REPLICATE});
        reg_write(`WIN_ADR_CONST, 8'h5a);
        read_check(`WIN_ADR_CONST, 8'h5a);
        reg_write(`WIN_ADR_MODE, 8'h03);
        read_check(`WIN_ADR_MODE, 8'h03);
        read_check(2'd2, 8'h00);
        read_check(2'd3, 8'h00);
        finish_test("register access");

        reg_write(`WIN_ADR_MODE, {6'b0, `WIN_BORDER_REFLECT_101});
        out_base = out_cnt;
        run_frame(6, 8, `WIN_BORDER_REFLECT_101, 8'h5a, 1'b1);
        wait_drain();
        count_check(48);
        finish_test("reflect_101 8x6");

        reg_write(`WIN_ADR_MODE, {6'b0, `WIN_BORDER_REPLICATE});
        run_frame(4, 5, `WIN_BORDER_REPLICATE, 8'h5a, 1'b0);
        wait_drain();
        finish_test("replicate 5x4");

        reg_write(`WIN_ADR_MODE, {6'b0, `WIN_BORDER_CONSTANT});
        reg_write(`WIN_ADR_CONST, 8'hff);
        make_frame(4, 5);
        queue_expected(4, 5, `WIN_BORDER_CONSTANT, 8'hff);
        // top-left corner sees five constant neighbors
        corner_exp = sum_t'(5 * 255 + int'(img[0]) + int'(img[1])
                            + int'(img[5]) + int'(img[6]));
        out_base = out_cnt;
        send_frame(4, 5, 1'b0);
        wait_drain();
        assert (first_beat.data == corner_exp) else begin
            $display("mismatch corner m_beat.data: got %h expected %h", first_beat.data,
                     corner_exp);
            err_cnt++;
        end
        finish_test("constant ff 5x4");

        reg_write(`WIN_ADR_MODE, {6'b0, `WIN_BORDER_REFLECT_101});
        out_base = out_cnt;
        run_frame(4, 1, `WIN_BORDER_REFLECT_101, 8'hff, 1'b1);
        run_frame(1, 4, `WIN_BORDER_REFLECT_101, 8'hff, 1'b1);
        run_frame(1, 1, `WIN_BORDER_REFLECT_101, 8'hff, 1'b1);
        wait_drain();
        count_check(9);
        finish_test("edge shapes");

        reg_write(`WIN_ADR_MODE, {6'b0, `WIN_BORDER_REPLICATE});
        make_frame(5, 6);
        queue_expected(5, 6, `WIN_BORDER_REPLICATE, 8'hff);
        fork
            send_frame(5, 6, 1'b0);
            begin
                repeat (10) @(posedge clk);
                #5;
                reg_write(`WIN_ADR_MODE, {6'b0, `WIN_BORDER_REFLECT_101});
            end
        join
        wait_drain();
        run_frame(5, 6, `WIN_BORDER_REFLECT_101, 8'hff, 1'b0);
        wait_drain();
        finish_test("mid-frame configuration");

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
source/win_stream_pkg.sv
source/win_cfg_pkg.sv
source/win_cfg_regs.sv
source/win_window_buf.sv
source/win_sum_result.sv
source/win_filter_top.sv
sim/tb_win_filter.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_win_filter -o tb_win_filter

sim_out="$(./obj_dir/tb_win_filter)"
echo "$sim_out"

if grep -q "^Testbench passed$" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
